//--- bridge_cfg.svh
// Bridge widths, outstanding depth and register index width
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// Address and data paths on both the client and AXI side
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32

// One strobe bit per data byte
`define BRIDGE_STRB_W (`BRIDGE_DATA_W / 8)

// Transactions in flight, counter runs 0 to this value
`define BRIDGE_MAX_OUTSTANDING 4

// Width needed to hold 0 to BRIDGE_MAX_OUTSTANDING
`define BRIDGE_CNT_W ($clog2(`BRIDGE_MAX_OUTSTANDING + 1))

// Four control and status registers
`define BRIDGE_REG_ADDR_W 2

`endif

//--- axi_pkg.sv
// AXI burst, size and response field types and their encodings
package axi_pkg;

	// ******************************
	// Field types
	// ******************************

	// Beats minus one
	typedef logic [7:0] len_t;

	// Bytes per beat as a power of two
	typedef logic [2:0] size_t;

	typedef logic [1:0] burst_t;
	typedef logic [1:0] resp_t;

	// ******************************
	// Encodings
	// ******************************

	// Incrementing burst, the only type the client normally asks for
	localparam burst_t BURST_INCR = 2'b01;

	// Normal completion
	localparam resp_t RESP_OKAY = 2'b00;

	// Slave saw the access but reported an error
	localparam resp_t RESP_SLVERR = 2'b10;

endpackage

//--- lpi_pkg.sv
// Client request and response words and the lock direction type
`include "bridge_cfg.svh"

package lpi_pkg;

	typedef logic [`BRIDGE_ADDR_W-1:0] addr_t;
	typedef logic [`BRIDGE_DATA_W-1:0] data_t;
	typedef logic [`BRIDGE_STRB_W-1:0] strb_t;

	// ******************************
	// Request word
	// ******************************

	// Packed from the top: write, len, size, burst, strb, wdata, addr
	typedef struct packed {
		logic write;
		axi_pkg::len_t len;
		axi_pkg::size_t size;
		axi_pkg::burst_t burst;
		strb_t strb;
		data_t wdata;
		addr_t addr;
	} req_t;

	// ******************************
	// Response word
	// ******************************

	// Data is zero for a B response
	typedef struct packed {
		logic is_write;
		axi_pkg::resp_t resp;
		data_t data;
	} rsp_t;

	// Direction that holds the lock, IDLE when nothing is in flight
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		READ = 2'd1,
		WRITE = 2'd2
	} dir_e;

endpackage

//--- outstanding_counter.sv
// Outstanding transaction counter with one-hot state, empty and full flags
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module outstanding_counter
(
	input  logic rvx_port_03,
	input  logic rvx_port_31,
	input  logic clear,
	input  logic up,
	input  logic down,
	input  logic [`BRIDGE_CNT_W-1:0] limit,
	output logic [`BRIDGE_CNT_W-1:0] count,
	output logic empty,
	output logic full
);

	localparam int DEPTH = `BRIDGE_MAX_OUTSTANDING;
	localparam int CNT_W = `BRIDGE_CNT_W;

	// Bit i high means i transactions in flight
	logic [DEPTH:0] onehot_q;

	always_ff @(posedge rvx_port_03 or negedge rvx_port_31)
	begin
		if (!rvx_port_31)
			onehot_q <= {{DEPTH{1'b0}}, 1'b1};
		else if (clear)
			onehot_q <= {{DEPTH{1'b0}}, 1'b1};
		else if (up && !down && !onehot_q[DEPTH])
			onehot_q <= {onehot_q[DEPTH-1:0], 1'b0};
		else if (down && !up && !onehot_q[0])
			onehot_q <= {1'b0, onehot_q[DEPTH:1]};
	end

	// Binary value for status and the limit compare
	always_comb
	begin
		count = '0;
		for (int i = 0; i <= DEPTH; i++)
		begin
			if (onehot_q[i])
				count = CNT_W'(i);
		end
	end

	assign empty = onehot_q[0];

	// Software limit, and the hard ceiling of the one-hot vector
	assign full = onehot_q[DEPTH] || (count >= limit);

	// A completion always belongs to an earlier issue
	a_no_down_when_empty: assert property (
		@(posedge rvx_port_03) disable iff (!rvx_port_31)
		down && !clear |-> !empty
	);

endmodule

//--- lpi_axi_bridge.sv
// Request decode, direction lock, write phase and AXI channel drive with response mux
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module lpi_axi_bridge
(
	input  logic rvx_port_03,
	input  logic rvx_port_31,
	input  logic enable,
	input  logic clear,

	// Client request and response
	input  logic req_valid,
	input  lpi_pkg::req_t req_word,
	output logic req_ready,
	output logic rsp_valid,
	output lpi_pkg::rsp_t rsp_word,
	input  logic rsp_ready,

	// AXI write address
	output logic [`BRIDGE_ADDR_W-1:0] awaddr,
	output axi_pkg::len_t awlen,
	output axi_pkg::size_t awsize,
	output axi_pkg::burst_t awburst,
	output logic awvalid,
	input  logic awready,

	// AXI write data, single beat
	output logic [`BRIDGE_DATA_W-1:0] wdata,
	output logic [`BRIDGE_STRB_W-1:0] wstrb,
	output logic wlast,
	output logic wvalid,
	input  logic wready,

	// AXI write response
	input  axi_pkg::resp_t bresp,
	input  logic bvalid,
	output logic bready,

	// AXI read address
	output logic [`BRIDGE_ADDR_W-1:0] araddr,
	output axi_pkg::len_t arlen,
	output axi_pkg::size_t arsize,
	output axi_pkg::burst_t arburst,
	output logic arvalid,
	input  logic arready,

	// AXI read data
	input  logic [`BRIDGE_DATA_W-1:0] rdata,
	input  axi_pkg::resp_t rresp,
	input  logic rlast,
	input  logic rvalid,
	output logic rready,

	// Counter and register block
	output logic cnt_up,
	output logic cnt_down,
	input  logic cnt_empty,
	input  logic cnt_full,
	output lpi_pkg::dir_e dir,
	output logic err_pulse
);

	lpi_pkg::dir_e dir_q;
	logic wphase_q;

	logic read_ok;
	logic write_ok;
	logic can_issue;
	logic rsp_is_b;

	logic aw_hs;
	logic w_hs;
	logic ar_hs;
	logic b_hs;
	logic r_hs;

	// ******************************
	// Issue side
	// ******************************

	// Lock follows the held direction, any direction once drained
	assign read_ok = cnt_empty || (dir_q == lpi_pkg::READ);
	assign write_ok = cnt_empty || (dir_q == lpi_pkg::WRITE);

	// No new address while the previous write still owes its W beat
	assign can_issue = enable && req_valid && !cnt_full && !wphase_q;

	assign awvalid = can_issue && req_word.write && write_ok;
	assign arvalid = can_issue && !req_word.write && read_ok;

	// W beat is owed once AW has gone, regardless of enable
	assign wvalid = wphase_q && req_valid;

	assign aw_hs = awvalid && awready;
	assign w_hs = wvalid && wready;
	assign ar_hs = arvalid && arready;
	assign b_hs = bvalid && bready;
	assign r_hs = rvalid && rready;

	// Request retires on W for writes and on AR for reads
	assign req_ready = req_word.write ? w_hs : ar_hs;

	assign awaddr = req_word.addr;
	assign awlen = req_word.len;
	assign awsize = req_word.size;
	assign awburst = req_word.burst;

	assign wdata = req_word.wdata;
	assign wstrb = req_word.strb;
	assign wlast = 1'b1;

	assign araddr = req_word.addr;
	assign arlen = req_word.len;
	assign arsize = req_word.size;
	assign arburst = req_word.burst;

	// Write phase, AW then W
	always_ff @(posedge rvx_port_03 or negedge rvx_port_31)
	begin
		if (!rvx_port_31)
			wphase_q <= 1'b0;
		else if (clear)
			wphase_q <= 1'b0;
		else if (aw_hs)
			wphase_q <= 1'b1;
		else if (w_hs)
			wphase_q <= 1'b0;
	end

	// Direction lock, taken on issue and dropped once drained
	always_ff @(posedge rvx_port_03 or negedge rvx_port_31)
	begin
		if (!rvx_port_31)
			dir_q <= lpi_pkg::IDLE;
		else if (clear)
			dir_q <= lpi_pkg::IDLE;
		else if (aw_hs)
			dir_q <= lpi_pkg::WRITE;
		else if (ar_hs)
			dir_q <= lpi_pkg::READ;
		else if (cnt_empty)
			dir_q <= lpi_pkg::IDLE;
	end

	assign dir = dir_q;

	// ******************************
	// Response side
	// ******************************

	assign rsp_is_b = (dir_q == lpi_pkg::WRITE);

	// Straight pass-through, only the locked channel is accepted
	assign bready = rsp_ready && rsp_is_b;
	assign rready = rsp_ready && (dir_q == lpi_pkg::READ);

	assign rsp_valid = rsp_is_b ? bvalid : (rvalid && (dir_q == lpi_pkg::READ));

	assign rsp_word.is_write = rsp_is_b;
	assign rsp_word.resp = rsp_is_b ? bresp : rresp;
	assign rsp_word.data = rsp_is_b ? '0 : rdata;

	assign cnt_up = aw_hs || ar_hs;
	assign cnt_down = b_hs || (r_hs && rlast);

	// Every beat with a non-OKAY response counts once
	assign err_pulse = (b_hs && (bresp != axi_pkg::RESP_OKAY)) ||
		(r_hs && (rresp != axi_pkg::RESP_OKAY));

	// Lock is held whenever anything is in flight, so AW and AR never mix
	a_lock_held_in_flight: assert property (
		@(posedge rvx_port_03) disable iff (!rvx_port_31)
		!cnt_empty |-> (dir_q != lpi_pkg::IDLE)
	);

	// W only after an AW handshake has taken the write lock
	a_w_in_phase: assert property (
		@(posedge rvx_port_03) disable iff (!rvx_port_31)
		wvalid |-> (dir_q == lpi_pkg::WRITE) && !cnt_empty
	);

endmodule

//--- bridge_ctrl_regs.sv
// Control registers for enable, clear and limit, status register and error counter
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module bridge_ctrl_regs
(
	input  logic rvx_port_03,
	input  logic rvx_port_31,
	input  logic reg_wr,
	input  logic [`BRIDGE_REG_ADDR_W-1:0] reg_addr,
	input  logic [`BRIDGE_DATA_W-1:0] reg_wdata,
	output logic [`BRIDGE_DATA_W-1:0] reg_rdata,
	output logic enable,
	output logic clear,
	output logic [`BRIDGE_CNT_W-1:0] limit,
	input  logic [`BRIDGE_CNT_W-1:0] count,
	input  lpi_pkg::dir_e dir,
	input  logic err_pulse
);

	localparam int CNT_W = `BRIDGE_CNT_W;
	localparam int DATA_W = `BRIDGE_DATA_W;

	logic [15:0] err_cnt_q;
	logic [DATA_W-1:0] status;

	// ******************************
	// Control writes
	// ******************************

	always_ff @(posedge rvx_port_03 or negedge rvx_port_31)
	begin
		if (!rvx_port_31)
		begin
			enable <= 1'b0;
			clear <= 1'b0;
			limit <= CNT_W'(`BRIDGE_MAX_OUTSTANDING);
		end
		else
		begin
			// Pulse lasts one cycle
			clear <= reg_wr && (reg_addr == 2'd1);
			if (reg_wr && (reg_addr == 2'd0))
				enable <= reg_wdata[0];
			if (reg_wr && (reg_addr == 2'd2))
			begin
				// Clamp to 1 .. max
				if (reg_wdata == '0)
					limit <= CNT_W'(1);
				else if (reg_wdata > DATA_W'(`BRIDGE_MAX_OUTSTANDING))
					limit <= CNT_W'(`BRIDGE_MAX_OUTSTANDING);
				else
					limit <= reg_wdata[CNT_W-1:0];
			end
		end
	end

	// Error responses, saturating, zeroed by the clear pulse
	always_ff @(posedge rvx_port_03 or negedge rvx_port_31)
	begin
		if (!rvx_port_31)
			err_cnt_q <= '0;
		else if (clear)
			err_cnt_q <= '0;
		else if (err_pulse && (err_cnt_q != '1))
			err_cnt_q <= err_cnt_q + 16'd1;
	end

	// Status layout: errors [31:16], dir [9:8], count from bit 0
	assign status = {err_cnt_q, 6'd0, dir, {(8-CNT_W){1'b0}}, count};

	// ******************************
	// Read port, one cycle latency
	// ******************************

	always_ff @(posedge rvx_port_03 or negedge rvx_port_31)
	begin
		if (!rvx_port_31)
			reg_rdata <= '0;
		else
		begin
			case (reg_addr)
				2'd0: reg_rdata <= {{(DATA_W-1){1'b0}}, enable};
				2'd2: reg_rdata <= {{(DATA_W-CNT_W){1'b0}}, limit};
				2'd3: reg_rdata <= status;
				default: reg_rdata <= '0;
			endcase
		end
	end

endmodule

//--- lpi_axi_top.sv
// Top level joining register block, bridge and outstanding counter
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module lpi_axi_top
(
	input  logic rvx_port_03,
	input  logic rvx_port_31,

	// Client
	input  logic req_valid,
	input  lpi_pkg::req_t req_word,
	output logic req_ready,
	output logic rsp_valid,
	output lpi_pkg::rsp_t rsp_word,
	input  logic rsp_ready,

	// Registers
	input  logic reg_wr,
	input  logic [`BRIDGE_REG_ADDR_W-1:0] reg_addr,
	input  logic [`BRIDGE_DATA_W-1:0] reg_wdata,
	output logic [`BRIDGE_DATA_W-1:0] reg_rdata,

	// AXI master
	output logic [`BRIDGE_ADDR_W-1:0] awaddr,
	output axi_pkg::len_t awlen,
	output axi_pkg::size_t awsize,
	output axi_pkg::burst_t awburst,
	output logic awvalid,
	input  logic awready,
	output logic [`BRIDGE_DATA_W-1:0] wdata,
	output logic [`BRIDGE_STRB_W-1:0] wstrb,
	output logic wlast,
	output logic wvalid,
	input  logic wready,
	input  axi_pkg::resp_t bresp,
	input  logic bvalid,
	output logic bready,
	output logic [`BRIDGE_ADDR_W-1:0] araddr,
	output axi_pkg::len_t arlen,
	output axi_pkg::size_t arsize,
	output axi_pkg::burst_t arburst,
	output logic arvalid,
	input  logic arready,
	input  logic [`BRIDGE_DATA_W-1:0] rdata,
	input  axi_pkg::resp_t rresp,
	input  logic rlast,
	input  logic rvalid,
	output logic rready
);

	logic enable;
	logic clear;
	logic [`BRIDGE_CNT_W-1:0] limit;
	logic [`BRIDGE_CNT_W-1:0] count;
	lpi_pkg::dir_e dir;
	logic err_pulse;
	logic cnt_up;
	logic cnt_down;
	logic cnt_empty;
	logic cnt_full;

	bridge_ctrl_regs u_regs
	(
		.rvx_port_03 (rvx_port_03),
		.rvx_port_31 (rvx_port_31),
		.reg_wr      (reg_wr),
		.reg_addr    (reg_addr),
		.reg_wdata   (reg_wdata),
		.reg_rdata   (reg_rdata),
		.enable      (enable),
		.clear       (clear),
		.limit       (limit),
		.count       (count),
		.dir         (dir),
		.err_pulse   (err_pulse)
	);

	lpi_axi_bridge u_bridge
	(
		.rvx_port_03 (rvx_port_03),
		.rvx_port_31 (rvx_port_31),
		.enable      (enable),
		.clear       (clear),
		.req_valid   (req_valid),
		.req_word    (req_word),
		.req_ready   (req_ready),
		.rsp_valid   (rsp_valid),
		.rsp_word    (rsp_word),
		.rsp_ready   (rsp_ready),
		.awaddr      (awaddr),
		.awlen       (awlen),
		.awsize      (awsize),
		.awburst     (awburst),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wlast       (wlast),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.araddr      (araddr),
		.arlen       (arlen),
		.arsize      (arsize),
		.arburst     (arburst),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rlast       (rlast),
		.rvalid      (rvalid),
		.rready      (rready),
		.cnt_up      (cnt_up),
		.cnt_down    (cnt_down),
		.cnt_empty   (cnt_empty),
		.cnt_full    (cnt_full),
		.dir         (dir),
		.err_pulse   (err_pulse)
	);

	outstanding_counter u_counter
	(
		.rvx_port_03 (rvx_port_03),
		.rvx_port_31 (rvx_port_31),
		.clear       (clear),
		.up          (cnt_up),
		.down        (cnt_down),
		.limit       (limit),
		.count       (count),
		.empty       (cnt_empty),
		.full        (cnt_full)
	);

endmodule

//--- tb_axi_slave_model.sv
// AXI slave memory model with fixed response latency, ready stalls and SLVERR above bit 31
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module tb_axi_slave_model
#(
	parameter int LATENCY = 6
)
(
	input  logic rvx_port_03,
	input  logic rvx_port_31,
	input  logic stall,
	input  logic [`BRIDGE_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [`BRIDGE_DATA_W-1:0] wdata,
	input  logic [`BRIDGE_STRB_W-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output axi_pkg::resp_t bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [`BRIDGE_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [`BRIDGE_DATA_W-1:0] rdata,
	output axi_pkg::resp_t rresp,
	output logic rlast,
	output logic rvalid,
	input  logic rready
);

	logic [31:0] mem [0:255];
	logic [31:0] aw_q [$];
	int due_q [$];
	bit isb_q [$];
	axi_pkg::resp_t resp_q [$];
	logic [31:0] data_q [$];
	int cyc;
	logic [31:0] a;

	// Fill pattern follows the byte address of each word
	initial
	begin
		for (int i = 0; i < 256; i++)
			mem[i] = 32'hc3a5_0000 | (i << 2);
	end

	assign awready = !stall;
	assign wready = !stall;
	assign arready = !stall;
	assign rlast = 1'b1;

	always @(posedge rvx_port_03 or negedge rvx_port_31)
	begin
		if (!rvx_port_31)
		begin
			cyc = 0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			bresp <= axi_pkg::RESP_OKAY;
			rresp <= axi_pkg::RESP_OKAY;
			rdata <= '0;
		end
		else
		begin
			cyc = cyc + 1;
			if ((bvalid && bready) || (rvalid && rready))
			begin
				void'(due_q.pop_front());
				void'(isb_q.pop_front());
				void'(resp_q.pop_front());
				void'(data_q.pop_front());
			end
			if (awvalid && awready)
				aw_q.push_back(awaddr);
			if (wvalid && wready)
			begin
				a = aw_q.pop_front();
				// Erroring writes leave memory untouched
				if (!a[31])
				begin
					for (int b = 0; b < 4; b++)
						if (wstrb[b])
							mem[a[9:2]][8*b +: 8] = wdata[8*b +: 8];
				end
				due_q.push_back(cyc + LATENCY);
				isb_q.push_back(1'b1);
				resp_q.push_back(a[31] ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY);
				data_q.push_back('0);
			end
			if (arvalid && arready)
			begin
				due_q.push_back(cyc + LATENCY);
				isb_q.push_back(1'b0);
				resp_q.push_back(araddr[31] ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY);
				data_q.push_back(mem[araddr[9:2]]);
			end
			// Head response shows once its latency has passed
			if (due_q.size() > 0 && due_q[0] <= cyc)
			begin
				bvalid <= isb_q[0];
				rvalid <= !isb_q[0];
				bresp <= resp_q[0];
				rresp <= resp_q[0];
				rdata <= data_q[0];
			end
			else
			begin
				bvalid <= 1'b0;
				rvalid <= 1'b0;
			end
		end
	end

endmodule

//--- tb_lpi_axi_top.sv
// Testbench for the request-to-AXI bridge: clock, reset, stimulus, assertions and report
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module tb_lpi_axi_top;

	// About 35 requests of under 25 cycles each plus register traffic, with wide margin
	localparam int TIMEOUT_CYCLES = 4000;

	logic rvx_port_03;
	logic rvx_port_31;
	logic req_valid;
	lpi_pkg::req_t req_word;
	logic req_ready;
	logic rsp_valid;
	lpi_pkg::rsp_t rsp_word;
	logic rsp_ready;
	logic reg_wr;
	logic [`BRIDGE_REG_ADDR_W-1:0] reg_addr;
	logic [`BRIDGE_DATA_W-1:0] reg_wdata;
	logic [`BRIDGE_DATA_W-1:0] reg_rdata;
	logic [31:0] awaddr;
	logic [31:0] araddr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	axi_pkg::len_t awlen;
	axi_pkg::len_t arlen;
	axi_pkg::size_t awsize;
	axi_pkg::size_t arsize;
	axi_pkg::burst_t awburst;
	axi_pkg::burst_t arburst;
	axi_pkg::resp_t bresp;
	axi_pkg::resp_t rresp;
	logic [3:0] wstrb;
	logic awvalid;
	logic awready;
	logic wlast;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic arvalid;
	logic arready;
	logic rlast;
	logic rvalid;
	logic rready;
	logic stall;

	int mismatches;
	int failures;
	int cycles;
	int tb_out;
	bit tb_dir_wr;
	int tb_limit;
	bit tb_enabled;
	logic [31:0] lfsr_q;
	string test_name;
	lpi_pkg::req_t cur_req;
	logic [31:0] shadow [logic [31:0]];
	logic [31:0] wr_addr [8];
	bit exp_isw [$];
	axi_pkg::resp_t exp_resp [$];
	bit exp_dchk [$];
	logic [31:0] exp_data [$];

	lpi_axi_top u_dut (.*);

	tb_axi_slave_model u_slave (.*);

	always #4 rvx_port_03 = ~rvx_port_03;

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic lpi_pkg::req_t make_req(input bit w, input logic [31:0] a,
		input logic [31:0] d, input logic [3:0] s);
		lpi_pkg::req_t r;
		r.write = w;
		r.len = 8'd0;
		r.size = 3'd2;
		r.burst = axi_pkg::BURST_INCR;
		r.strb = s;
		r.wdata = d;
		r.addr = a;
		return r;
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		mismatches++;
		$display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
	endtask

	task automatic write_reg(input logic [1:0] a, input logic [31:0] d);
		@(posedge rvx_port_03);
		reg_wr <= 1'b1;
		reg_addr <= a;
		reg_wdata <= d;
		@(posedge rvx_port_03);
		reg_wr <= 1'b0;
	endtask

	task automatic read_reg(input logic [1:0] a, output logic [31:0] v);
		@(posedge rvx_port_03);
		reg_addr <= a;
		@(posedge rvx_port_03);
		@(negedge rvx_port_03);
		v = reg_rdata;
	endtask

	// Present one request, record its expected response, return once taken
	task automatic issue_req(input lpi_pkg::req_t r);
		logic [31:0] old;
		@(posedge rvx_port_03);
		req_valid <= 1'b1;
		req_word <= r;
		cur_req = r;
		do
			@(negedge rvx_port_03);
		while (!req_ready);
		exp_isw.push_back(r.write);
		exp_resp.push_back(r.addr[31] ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY);
		exp_dchk.push_back(r.write || (!r.addr[31] && shadow.exists(r.addr)));
		exp_data.push_back((!r.write && shadow.exists(r.addr)) ? shadow[r.addr] : 32'd0);
		if (r.write && !r.addr[31])
		begin
			old = shadow.exists(r.addr) ? shadow[r.addr] : 32'd0;
			for (int b = 0; b < 4; b++)
				if (r.strb[b])
					old[8*b +: 8] = r.wdata[8*b +: 8];
			shadow[r.addr] = old;
		end
		@(posedge rvx_port_03);
		req_valid <= 1'b0;
	endtask

	task automatic wait_drained();
		do
			@(negedge rvx_port_03);
		while (tb_out != 0 || exp_isw.size() != 0);
	endtask

	// Ready stalls on the client and slave sides
	always @(posedge rvx_port_03)
	begin
		if (rvx_port_31)
		begin
			rsp_ready <= (rand_bits(2) != 0);
			stall <= (rand_bits(2) == 0);
		end
	end

	// Reference count of transactions in flight
	always @(posedge rvx_port_03 or negedge rvx_port_31)
	begin
		if (!rvx_port_31)
			tb_out <= 0;
		else
			tb_out <= tb_out + ((awvalid && awready) || (arvalid && arready))
				- ((bvalid && bready) || (rvalid && rready && rlast));
		if (rvx_port_31 && awvalid && awready)
			tb_dir_wr <= 1'b1;
		else if (rvx_port_31 && arvalid && arready)
			tb_dir_wr <= 1'b0;
	end

	// Channel field and response checks, one half cycle before each handshake edge
	always @(negedge rvx_port_03)
	begin
		if (rvx_port_31 && awvalid && awready)
		begin
			assert (awaddr == cur_req.addr) else report_mismatch("awaddr", cur_req.addr, awaddr);
			assert (awlen == cur_req.len) else report_mismatch("awlen", cur_req.len, awlen);
			assert (awsize == cur_req.size) else report_mismatch("awsize", cur_req.size, awsize);
			assert (awburst == cur_req.burst)
				else report_mismatch("awburst", cur_req.burst, awburst);
		end
		if (rvx_port_31 && wvalid && wready)
		begin
			assert (wdata == cur_req.wdata) else report_mismatch("wdata", cur_req.wdata, wdata);
			assert (wstrb == cur_req.strb) else report_mismatch("wstrb", cur_req.strb, wstrb);
			assert (wlast) else report_mismatch("wlast", 1, wlast);
		end
		if (rvx_port_31 && arvalid && arready)
		begin
			assert (araddr == cur_req.addr) else report_mismatch("araddr", cur_req.addr, araddr);
			assert (arlen == cur_req.len) else report_mismatch("arlen", cur_req.len, arlen);
			assert (arsize == cur_req.size) else report_mismatch("arsize", cur_req.size, arsize);
			assert (arburst == cur_req.burst)
				else report_mismatch("arburst", cur_req.burst, arburst);
		end
		if (rvx_port_31 && rsp_valid && rsp_ready)
		begin
			if (exp_isw.size() == 0)
			begin
				failures++;
				$display("Response arrived with no request outstanding in %s", test_name);
			end
			else
			begin
				assert (rsp_word.is_write == exp_isw[0])
					else report_mismatch("is_write", exp_isw[0], rsp_word.is_write);
				assert (rsp_word.resp == exp_resp[0])
					else report_mismatch("resp", exp_resp[0], rsp_word.resp);
				assert (!exp_dchk[0] || rsp_word.data == exp_data[0])
					else report_mismatch("data", exp_data[0], rsp_word.data);
				void'(exp_isw.pop_front());
				void'(exp_resp.pop_front());
				void'(exp_dchk.pop_front());
				void'(exp_data.pop_front());
			end
		end
	end

	a_idle_when_disabled: assert property (@(posedge rvx_port_03) disable iff (!rvx_port_31)
		!tb_enabled |-> !(awvalid || arvalid || wvalid))
		else
		begin
			failures++;
			$display("AXI valid rose while the bridge was disabled");
		end

	a_write_waits_reads: assert property (@(posedge rvx_port_03) disable iff (!rvx_port_31)
		awvalid |-> (tb_out == 0 || tb_dir_wr))
		else
		begin
			failures++;
			$display("Write address issued while reads were in flight");
		end

	a_read_waits_writes: assert property (@(posedge rvx_port_03) disable iff (!rvx_port_31)
		arvalid |-> (tb_out == 0 || !tb_dir_wr))
		else
		begin
			failures++;
			$display("Read address issued while writes were in flight");
		end

	a_count_within_limit: assert property (@(posedge rvx_port_03) disable iff (!rvx_port_31)
		tb_out <= tb_limit)
		else
		begin
			failures++;
			$display("More transactions in flight than the limit");
		end

	a_hold_at_limit: assert property (@(posedge rvx_port_03) disable iff (!rvx_port_31)
		(tb_out >= tb_limit && !wvalid) |-> !req_ready)
		else
		begin
			failures++;
			$display("Request accepted while the limit was reached");
		end

	// Client back-pressure reaches the AXI response channels
	a_ready_follows_client: assert property (@(posedge rvx_port_03) disable iff (!rvx_port_31)
		(bready || rready) |-> rsp_ready)
		else
		begin
			failures++;
			$display("BREADY or RREADY high while the client held off responses");
		end

	always @(posedge rvx_port_03)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial
	begin
		logic [31:0] v;
		logic [31:0] a;
		logic [15:0] err_before;
		rvx_port_03 = 1'b0;
		rvx_port_31 = 1'b0;
		req_valid = 1'b0;
		req_word = '0;
		rsp_ready = 1'b0;
		reg_wr = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		stall = 1'b0;
		mismatches = 0;
		failures = 0;
		cycles = 0;
		tb_limit = `BRIDGE_MAX_OUTSTANDING;
		tb_enabled = 1'b0;
		tb_dir_wr = 1'b0;
		lfsr_q = 32'h93fe;
		repeat (10) @(posedge rvx_port_03);
		rvx_port_31 <= 1'b1;

		// ******************************
		// Disabled bridge stays quiet
		// ******************************
		test_name = "disabled";
		@(posedge rvx_port_03);
		req_valid <= 1'b1;
		req_word <= make_req(1'b1, 32'h40, 32'h1234_5678, 4'hf);
		repeat (20) @(posedge rvx_port_03);
		req_valid <= 1'b0;
		write_reg(2'd0, 32'd1);
		@(posedge rvx_port_03);
		tb_enabled = 1'b1;

		test_name = "write";
		for (int i = 0; i < 8; i++)
		begin
			wr_addr[i] = {22'd0, 8'(rand_bits(8)), 2'b00};
			issue_req(make_req(1'b1, wr_addr[i], rand_bits(32), 4'hf));
		end
		for (int i = 0; i < 2; i++)
			issue_req(make_req(1'b1, wr_addr[i], rand_bits(32), 4'(rand_bits(4))));

		test_name = "read";
		for (int i = 0; i < 8; i++)
			issue_req(make_req(1'b0, wr_addr[i], 32'd0, 4'h0));
		wait_drained();

		// Write queued behind reads, then reads behind the write
		test_name = "lock";
		for (int i = 0; i < 3; i++)
			issue_req(make_req(1'b0, wr_addr[i], 32'd0, 4'h0));
		issue_req(make_req(1'b1, wr_addr[3], rand_bits(32), 4'hf));
		issue_req(make_req(1'b0, wr_addr[3], 32'd0, 4'h0));
		issue_req(make_req(1'b0, wr_addr[4], 32'd0, 4'h0));
		wait_drained();

		test_name = "limit";
		write_reg(2'd2, 32'd2);
		tb_limit = 2;
		fork
			for (int i = 0; i < 8; i++)
				issue_req(make_req(1'b0, wr_addr[i], 32'd0, 4'h0));
			repeat (20)
			begin
				read_reg(2'd3, v);
				assert (v[`BRIDGE_CNT_W-1:0] <= 2)
					else report_mismatch("status count", 2, v[`BRIDGE_CNT_W-1:0]);
			end
		join
		wait_drained();
		write_reg(2'd2, `BRIDGE_MAX_OUTSTANDING);
		@(posedge rvx_port_03);
		tb_limit = `BRIDGE_MAX_OUTSTANDING;

		test_name = "errors";
		read_reg(2'd3, v);
		err_before = v[31:16];
		for (int i = 0; i < 2; i++)
		begin
			a = 32'h8000_0000 | {22'd0, 8'(rand_bits(8)), 2'b00};
			issue_req(make_req(1'b1, a, rand_bits(32), 4'hf));
		end
		issue_req(make_req(1'b0, 32'h8000_0080, 32'd0, 4'h0));
		wait_drained();
		read_reg(2'd3, v);
		assert (v[31:16] == err_before + 16'd3)
			else report_mismatch("error count", err_before + 16'd3, v[31:16]);
		write_reg(2'd1, 32'd0);
		read_reg(2'd3, v);
		assert (v[31:16] == 16'd0) else report_mismatch("error count cleared", 0, v[31:16]);

		$display("Checks done: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- lpi_axi_top.f
+incdir+.
axi_pkg.sv
lpi_pkg.sv
outstanding_counter.sv
lpi_axi_bridge.sv
bridge_ctrl_regs.sv
lpi_axi_top.sv
tb_axi_slave_model.sv
tb_lpi_axi_top.sv

//--- Bender.yml
package:
  name: lpi_axi_bridge

sources:
  - include_dirs:
      - .
    files:
      - axi_pkg.sv
      - lpi_pkg.sv
      - outstanding_counter.sv
      - lpi_axi_bridge.sv
      - bridge_ctrl_regs.sv
      - lpi_axi_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_axi_slave_model.sv
      - tb_lpi_axi_top.sv
